/* devtbl.f */
+incdir+include
hw/devtbl_pkg.sv
hw/sysctl_pkg.sv
hw/devtbl_rom.sv
hw/sysctl_regs.sv
hw/devtbl_apb.sv
hw/devtbl_top.sv
dv/devtbl_tb.sv

/* dv/devtbl_tb.sv */
////////////////////////////////////////
// Testbench for the device table slave, replaying APB
// transfers from the test data file.
////////////////////////////////////////
`timescale 1ns/10ps
`include "devtbl_consts.svh"

module devtbl_tb;

	logic                      clk_i;
	logic                      rst_i;
	logic                      psel_i;
	logic                      penable_i;
	logic                      pwrite_i;
	logic [`DEVTBL_ADDR_W-1:0] paddr_i;
	logic [`DEVTBL_DATA_W-1:0] pwdata_i;
	logic [`DEVTBL_DATA_W-1:0] prdata_o;
	logic                      pready_o;
	logic                      pslverr_o;
	logic                      core0_rst_o;
	logic                      core1_rst_o;
	logic                      ldr_exit_o;

	// One entry per transfer line of the data file.
	logic                      vec_wr[$];
	logic [`DEVTBL_ADDR_W-1:0] vec_addr[$];
	logic [`DEVTBL_DATA_W-1:0] vec_wdata[$];
	logic [`DEVTBL_DATA_W-1:0] vec_rdata[$];
	logic [3:0]                vec_outs[$];

	int   num_vec;
	int   errors;
	int   checks;
	logic loaded;

	devtbl_top i_dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.core0_rst_o (core0_rst_o),
		.core1_rst_o (core1_rst_o),
		.ldr_exit_o  (ldr_exit_o)
	);

	always #4 clk_i = ~clk_i;

	task automatic check_value(input string sig_name, input logic [31:0] got,
			input logic [31:0] exp, input int vec);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s got 0x%08h expected 0x%08h at transfer %0d",
				sig_name, got, exp, vec);
		end
	endtask

	task automatic load_vectors();
		int    fd;
		int    cnt;
		string line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [3:0]  err;
		logic [3:0]  c0;
		logic [3:0]  c1;
		logic [3:0]  ldr;
		fd = $fopen("dv/devtbl_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the test data file dv/devtbl_testdata.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%s %h %h %h %h %h %h %h",
				op, addr, wdata, rdata, err, c0, c1, ldr);
			if (cnt != 8) begin
				errors++;
				$display("test data line could not be parsed: %s", line);
				continue;
			end
			vec_wr.push_back(op == "W");
			vec_addr.push_back(addr[`DEVTBL_ADDR_W-1:0]);
			vec_wdata.push_back(wdata);
			vec_rdata.push_back(rdata);
			// Order is pslverr, core0, core1, ldr_exit from the top bit down.
			vec_outs.push_back({err[0], c0[0], c1[0], ldr[0]});
		end
		$fclose(fd);
		num_vec = vec_wr.size();
		if (num_vec == 0) begin
			errors++;
			$display("the test data file holds no transfers");
		end
	endtask

	// Setup on one falling edge, access on the next, then wait for pready.
	// Outputs are sampled 1 ns after a falling edge, well away from the rising edge.
	task automatic run_transfer(input int vec);
		int          cycles;
		int          exp_cycles;
		logic [31:0] got_rdata;
		logic        got_err;
		@(negedge clk_i);
		psel_i    = 1'b1;
		penable_i = 1'b0;
		pwrite_i  = vec_wr[vec];
		paddr_i   = vec_addr[vec];
		pwdata_i  = vec_wr[vec] ? vec_wdata[vec] : '0;
		cycles    = 1;
		@(negedge clk_i);
		penable_i = 1'b1;
		cycles    = 2;
		#1;
		while (!pready_o) begin
			@(negedge clk_i);
			#1;
			cycles++;
		end
		got_rdata = prdata_o;
		got_err   = pslverr_o;
		exp_cycles = vec_wr[vec] ? 2 : 3;
		checks++;
		assert (cycles == exp_cycles) else begin
			errors++;
			$display("transfer %0d took %0d cycles instead of %0d", vec, cycles, exp_cycles);
		end
		if (!vec_wr[vec]) begin
			check_value("prdata_o", got_rdata, vec_rdata[vec], vec);
		end
		check_value("pslverr_o", 32'(got_err), 32'(vec_outs[vec][3]), vec);
		@(negedge clk_i);
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		#1;
		check_value("core0_rst_o", 32'(core0_rst_o), 32'(vec_outs[vec][2]), vec);
		check_value("core1_rst_o", 32'(core1_rst_o), 32'(vec_outs[vec][1]), vec);
		check_value("ldr_exit_o", 32'(ldr_exit_o), 32'(vec_outs[vec][0]), vec);
	endtask

	initial begin
		clk_i     = 1'b0;
		rst_i     = 1'b1;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
		paddr_i   = '0;
		pwdata_i  = '0;
		errors    = 0;
		checks    = 0;
		num_vec   = 0;
		loaded    = 1'b0;
		load_vectors();
		loaded = 1'b1;
		repeat (8) @(negedge clk_i);
		rst_i = 1'b0;
		#1;
		check_value("pready_o", 32'(pready_o), 32'd0, -1);
		check_value("pslverr_o", 32'(pslverr_o), 32'd0, -1);
		check_value("prdata_o", prdata_o, 32'd0, -1);
		check_value("core0_rst_o", 32'(core0_rst_o), 32'd0, -1);
		check_value("core1_rst_o", 32'(core1_rst_o), 32'd0, -1);
		check_value("ldr_exit_o", 32'(ldr_exit_o), 32'd0, -1);
		for (int i = 0; i < num_vec; i++) begin
			run_transfer(i);
		end
		@(negedge clk_i);
		$display("transfers %0d, checks %0d, errors %0d", num_vec, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Each transfer needs at most five cycles including the idle one.
	initial begin
		wait (loaded);
		repeat (10 * num_vec + 100) @(posedge clk_i);
		$display("timeout, the run did not finish within %0d cycles", 10 * num_vec + 100);
		$display("transfers %0d, checks %0d, errors %0d", num_vec, checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* dv/devtbl_testdata.txt */
# Columns: op addr wdata exp_prdata exp_pslverr exp_core0 exp_core1 exp_ldr_exit
# op is R or W, the rest is hex; the last three are checked one cycle after completion.
# Table words, kind then size and flags for each device.
R 000 00000000 00000004 0 0 0 0
R 004 00000000 00000201 0 0 0 0
R 008 00000000 00000007 0 0 0 0
R 00C 00000000 00000DF0 0 0 0 0
R 010 00000000 00000003 0 0 0 0
R 014 00000000 00000008 0 0 0 0
R 018 00000000 00000005 0 0 0 0
R 01C 00000000 00000009 0 0 0 0
R 020 00000000 00000001 0 0 0 0
R 024 00000000 01000000 0 0 0 0
R 028 00000000 00000000 0 0 0 0
R 02C 00000000 00000040 0 0 0 0
# Past the last device but inside the table region.
R 030 00000000 00000000 0 0 0 0
R DEC 00000000 00000000 0 0 0 0
# Queries, the selector starts at version.
R E04 00000000 00010203 0 0 0 0
W E00 00000001 00000000 0 0 0 0
R E04 00000000 00004000 0 0 0 0
W E00 00000002 00000000 0 0 0 0
R E04 00000000 00000000 0 0 0 0
# Hold commands, followed by the reset state query.
W E08 00000000 00000000 0 1 0 0
R E04 00000000 00000001 0 1 0 0
W E08 00000001 00000000 0 0 1 0
R E04 00000000 00000002 0 0 1 0
W E08 00000002 00000000 0 1 1 0
R E04 00000000 00000003 0 1 1 0
# Commands above 3 change nothing.
W E08 00000005 00000000 0 1 1 0
W E08 00000004 00000000 0 1 1 0
R E04 00000000 00000003 0 1 1 0
W E08 00000000 00000000 0 1 0 0
# Preloader address, then exit.
W E00 00000003 00000000 0 1 0 0
R E04 00000000 00001000 0 1 0 0
W E08 00000003 00000000 0 1 0 1
R E04 00000000 00000000 0 1 0 0
# Error responses.
W 000 DEADBEEF 00000000 1 1 0 0
R 000 00000000 00000004 0 1 0 0
R DF0 00000000 00000000 1 1 0 0
W DF4 00000002 00000000 1 1 0 0
R E0C 00000000 00000000 1 1 0 0
W E0C 00000002 00000000 1 1 0 0
R FFC 00000000 00000000 1 1 0 0
R E00 00000000 00000000 1 1 0 0
W E04 00000000 00000000 1 1 0 0
# State is unchanged after the errors.
W E00 00000002 00000000 0 1 0 0
R E04 00000000 00000001 0 1 0 0
W E00 00000000 00000000 0 1 0 0
R E04 00000000 00010203 0 1 0 0

/* hw/devtbl_apb.sv */
////////////////////////////////////////
// APB slave for the device table and the control window.
////////////////////////////////////////
`timescale 1ns/10ps
`include "devtbl_consts.svh"

module devtbl_apb (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [`DEVTBL_ADDR_W-1:0]  paddr_i,
	input  logic [`DEVTBL_DATA_W-1:0]  pwdata_i,
	output logic [`DEVTBL_DATA_W-1:0]  prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	output logic                       tbl_rd_o,
	output logic [`DEVTBL_IDX_W-1:0]   tbl_idx_o,
	input  logic [`DEVTBL_DATA_W-1:0]  tbl_word_i,
	output logic                       ctl_wr_o,
	output logic                       ctl_rd_o,
	output logic [1:0]                 ctl_ofs_o,
	output logic [`DEVTBL_DATA_W-1:0]  ctl_wdata_o,
	input  logic [`DEVTBL_DATA_W-1:0]  ctl_rdata_i
);

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_access  = 2'd1;
	localparam logic [1:0] st_rd_done = 2'd2;

	localparam logic [`DEVTBL_ADDR_W-1:0] tbl_end    = `DEVTBL_TBL_END;
	localparam logic [`DEVTBL_ADDR_W-1:0] win_base   = `SYSCTL_BASE;
	localparam logic [`DEVTBL_ADDR_W-1:0] sel_ofs    = `SYSCTL_SEL_OFS;
	localparam logic [`DEVTBL_ADDR_W-1:0] result_ofs = `SYSCTL_RESULT_OFS;
	localparam logic [`DEVTBL_ADDR_W-1:0] cmd_ofs    = `SYSCTL_CMD_OFS;

	logic [1:0]                state_q;
	logic [1:0]                state_d;
	logic [`DEVTBL_ADDR_W-1:0] win_ofs;
	logic                      hit_tbl;
	logic                      hit_win;
	logic                      acc_err;

	assign hit_tbl     = (paddr_i < tbl_end);
	assign hit_win     = (paddr_i >= win_base);
	assign win_ofs     = paddr_i - win_base;
	assign tbl_idx_o   = paddr_i[`DEVTBL_ADDR_W-1:2];
	assign ctl_ofs_o   = win_ofs[3:2];
	assign ctl_wdata_o = pwdata_i;

	// Everything in the gap and every unlisted window offset is an error.
	always_comb begin
		if (hit_tbl) begin
			acc_err = pwrite_i;
		end else if (hit_win && win_ofs == sel_ofs) begin
			acc_err = !pwrite_i;
		end else if (hit_win && win_ofs == result_ofs) begin
			acc_err = pwrite_i;
		end else if (hit_win && win_ofs == cmd_ofs) begin
			acc_err = 1'b0;
		end else begin
			acc_err = 1'b1;
		end
	end

	always_comb begin
		state_d   = state_q;
		pready_o  = 1'b0;
		pslverr_o = 1'b0;
		prdata_o  = '0;
		tbl_rd_o  = 1'b0;
		ctl_rd_o  = 1'b0;
		ctl_wr_o  = 1'b0;
		case (state_q)
			st_idle: begin
				if (psel_i && !penable_i) begin
					state_d = st_access;
				end
			end
			st_access: begin
				if (pwrite_i) begin
					pready_o  = 1'b1;
					pslverr_o = acc_err;
					ctl_wr_o  = hit_win && !acc_err;
					state_d   = st_idle;
				end else begin
					tbl_rd_o = hit_tbl;
					ctl_rd_o = hit_win && !acc_err;
					state_d  = st_rd_done;
				end
			end
			st_rd_done: begin
				pready_o  = 1'b1;
				pslverr_o = acc_err;
				if (!acc_err) begin
					prdata_o = hit_tbl ? tbl_word_i : ctl_rdata_i;
				end
				state_d = st_idle;
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
		pready_o |-> psel_i && penable_i);

	// A read decodes paddr again in its second access cycle, so its error must match the first.
	rd_err_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		state_q == st_access && !pwrite_i |=> pslverr_o == $past(acc_err));

endmodule

/* hw/devtbl_pkg.sv */
////////////////////////////////////////
// Device kind codes, map flags and the table word views.
////////////////////////////////////////
package devtbl_pkg;

	// Kind codes as software expects them in the even table word.
	typedef enum logic [7:0] {
		kind_none       = 8'd0,
		kind_ram        = 8'd1,
		kind_tiny_timer = 8'd3,
		kind_block_dev  = 8'd4,
		kind_tiny_intc  = 8'd5,
		kind_dev_table  = 8'd7
	} dev_kind_e;

	typedef enum logic [1:0] {
		flag_plain = 2'd0,
		flag_intr  = 2'd1
	} map_flags_e;

	// Even word of a device entry.
	typedef struct packed {
		logic [23:0] rsvd;
		dev_kind_e   kind;
	} kind_word_t;

	// Odd word of a device entry.
	typedef struct packed {
		logic [29:0] map_sz;
		map_flags_e  flags;
	} size_word_t;

	// Bit 0 of the word index picks the view.
	typedef union packed {
		kind_word_t kind_w;
		size_word_t size_w;
	} tbl_word_u;

endpackage

/* hw/devtbl_rom.sv */
////////////////////////////////////////
// Registered device table lookup.
////////////////////////////////////////
`timescale 1ns/10ps
`include "devtbl_consts.svh"

module devtbl_rom (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  logic                   rd_i,
	input  logic [`DEVTBL_IDX_W-1:0] idx_i,
	output devtbl_pkg::tbl_word_u  word_o
);

	logic [`DEVTBL_IDX_W-2:0] dev_idx;
	devtbl_pkg::dev_kind_e    kind;
	devtbl_pkg::map_flags_e   flags;
	logic [29:0]              map_sz;
	devtbl_pkg::tbl_word_u    next_w;

	// Two words per device, so the upper index bits select the device.
	assign dev_idx = idx_i[`DEVTBL_IDX_W-1:1];

	always_comb begin
		kind   = devtbl_pkg::kind_none;
		flags  = devtbl_pkg::flag_plain;
		map_sz = '0;
		case (dev_idx)
			9'd0: begin
				kind   = devtbl_pkg::kind_block_dev;
				map_sz = `BLOCKDEV_MAPSZ;
				flags  = devtbl_pkg::flag_intr;
			end
			9'd1: begin
				kind   = devtbl_pkg::kind_dev_table;
				map_sz = `DEVTBL_MAPSZ;
			end
			9'd2: begin
				kind   = devtbl_pkg::kind_tiny_timer;
				map_sz = `TINYDEV_MAPSZ;
			end
			9'd3: begin
				kind   = devtbl_pkg::kind_tiny_intc;
				map_sz = `TINYDEV_MAPSZ;
				flags  = devtbl_pkg::flag_intr;
			end
			9'd4: begin
				kind   = devtbl_pkg::kind_ram;
				map_sz = `RAM_MAPSZ;
			end
			// The RAM controller lists no kind of its own.
			9'd5: begin
				map_sz = `RAMCTRL_MAPSZ;
			end
			default: begin
				map_sz = '0;
			end
		endcase
	end

	always_comb begin
		next_w = '0;
		if (dev_idx < `DEVTBL_NUM_DEV) begin
			if (idx_i[0]) begin
				next_w.size_w.map_sz = map_sz;
				next_w.size_w.flags  = flags;
			end else begin
				next_w.kind_w.kind = kind;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			word_o <= '0;
		end else if (rd_i) begin
			word_o <= next_w;
		end
	end

endmodule

/* hw/devtbl_top.sv */
////////////////////////////////////////
// Device table and system control slave.
////////////////////////////////////////
`timescale 1ns/10ps
`include "devtbl_consts.svh"

module devtbl_top (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      psel_i,
	input  logic                      penable_i,
	input  logic                      pwrite_i,
	input  logic [`DEVTBL_ADDR_W-1:0] paddr_i,
	input  logic [`DEVTBL_DATA_W-1:0] pwdata_i,
	output logic [`DEVTBL_DATA_W-1:0] prdata_o,
	output logic                      pready_o,
	output logic                      pslverr_o,
	output logic                      core0_rst_o,
	output logic                      core1_rst_o,
	output logic                      ldr_exit_o
);

	logic                      tbl_rd;
	logic [`DEVTBL_IDX_W-1:0]  tbl_idx;
	devtbl_pkg::tbl_word_u     tbl_word;
	logic                      ctl_wr;
	logic                      ctl_rd;
	logic [1:0]                ctl_ofs;
	logic [`DEVTBL_DATA_W-1:0] ctl_wdata;
	logic [`DEVTBL_DATA_W-1:0] ctl_rdata;

	devtbl_apb i_apb (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.tbl_rd_o    (tbl_rd),
		.tbl_idx_o   (tbl_idx),
		.tbl_word_i  (tbl_word),
		.ctl_wr_o    (ctl_wr),
		.ctl_rd_o    (ctl_rd),
		.ctl_ofs_o   (ctl_ofs),
		.ctl_wdata_o (ctl_wdata),
		.ctl_rdata_i (ctl_rdata)
	);

	devtbl_rom i_rom (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.rd_i   (tbl_rd),
		.idx_i  (tbl_idx),
		.word_o (tbl_word)
	);

	sysctl_regs i_ctl (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.wr_i        (ctl_wr),
		.rd_i        (ctl_rd),
		.ofs_i       (ctl_ofs),
		.wdata_i     (ctl_wdata),
		.rdata_o     (ctl_rdata),
		.core0_rst_o (core0_rst_o),
		.core1_rst_o (core1_rst_o),
		.ldr_exit_o  (ldr_exit_o)
	);

endmodule

/* hw/sysctl_pkg.sv */
////////////////////////////////////////
// Query selector and reset command codes.
////////////////////////////////////////
package sysctl_pkg;

	typedef enum logic [1:0] {
		query_version   = 2'd0,
		query_cache_sz  = 2'd1,
		query_rst_state = 2'd2,
		query_preldr    = 2'd3
	} query_e;

	// Commands written to the command register.
	typedef enum logic [1:0] {
		cmd_hold_core0  = 2'd0,
		cmd_hold_core1  = 2'd1,
		cmd_hold_both   = 2'd2,
		cmd_exit_preldr = 2'd3
	} rst_cmd_e;

endpackage

/* hw/sysctl_regs.sv */
////////////////////////////////////////
// System control registers, query result and core reset control.
////////////////////////////////////////
`timescale 1ns/10ps
`include "devtbl_consts.svh"

module sysctl_regs (
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      wr_i,
	input  logic                      rd_i,
	input  logic [1:0]                ofs_i,
	input  logic [`DEVTBL_DATA_W-1:0] wdata_i,
	output logic [`DEVTBL_DATA_W-1:0] rdata_o,
	output logic                      core0_rst_o,
	output logic                      core1_rst_o,
	output logic                      ldr_exit_o
);

	localparam logic [`DEVTBL_ADDR_W-1:0] sel_ofs    = `SYSCTL_SEL_OFS;
	localparam logic [`DEVTBL_ADDR_W-1:0] result_ofs = `SYSCTL_RESULT_OFS;
	localparam logic [`DEVTBL_ADDR_W-1:0] cmd_ofs    = `SYSCTL_CMD_OFS;

	sysctl_pkg::query_e          sel_q;
	sysctl_pkg::rst_cmd_e        cmd;
	logic                        ldr_done_q;
	logic                        code_ok;
	logic [`DEVTBL_DATA_W-1:0]   result;

	// Codes above 3 are ignored for both the selector and the command.
	assign code_ok = (wdata_i[`DEVTBL_DATA_W-1:2] == '0);
	assign cmd     = sysctl_pkg::rst_cmd_e'(wdata_i[1:0]);

	always_comb begin
		case (sel_q)
			sysctl_pkg::query_version:   result = `SOC_VERSION;
			sysctl_pkg::query_cache_sz:  result = `RAM_CACHE_SZ;
			sysctl_pkg::query_rst_state: result = {30'd0, core1_rst_o, core0_rst_o};
			default:                     result = ldr_done_q ? '0 : `PRELDR_ADDR;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sel_q       <= sysctl_pkg::query_version;
			core0_rst_o <= 1'b0;
			core1_rst_o <= 1'b0;
			ldr_done_q  <= 1'b0;
			ldr_exit_o  <= 1'b0;
			rdata_o     <= '0;
		end else begin
			ldr_exit_o <= 1'b0;
			if (wr_i && ofs_i == sel_ofs[3:2] && code_ok) begin
				sel_q <= sysctl_pkg::query_e'(wdata_i[1:0]);
			end
			if (wr_i && ofs_i == cmd_ofs[3:2] && code_ok) begin
				case (cmd)
					sysctl_pkg::cmd_hold_core0: begin
						core0_rst_o <= 1'b1;
						core1_rst_o <= 1'b0;
					end
					sysctl_pkg::cmd_hold_core1: begin
						core0_rst_o <= 1'b0;
						core1_rst_o <= 1'b1;
					end
					sysctl_pkg::cmd_hold_both: begin
						core0_rst_o <= 1'b1;
						core1_rst_o <= 1'b1;
					end
					default: begin
						ldr_done_q <= 1'b1;
						ldr_exit_o <= 1'b1;
					end
				endcase
			end
			if (rd_i && ofs_i == result_ofs[3:2]) begin
				rdata_o <= result;
			end
		end
	end

	// Back-to-back command writes cannot occur on the bus, so the exit pulse stays single.
	ldr_exit_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ldr_exit_o |=> !ldr_exit_o);

endmodule

/* include/devtbl_consts.svh */
////////////////////////////////////////
// Fixed sizes, table geometry, control window offsets
// and the values returned by the system queries.
////////////////////////////////////////
`ifndef DEVTBL_CONSTS_SVH
`define DEVTBL_CONSTS_SVH

// Bus widths.
`define DEVTBL_DATA_W 32
`define DEVTBL_ADDR_W 12

// Word index into the slave, byte address bits [11:2].
`define DEVTBL_IDX_W 10

// Number of devices listed, two table words each.
`define DEVTBL_NUM_DEV 6

// Table region in words. The slave is 4 KB with the top 512 bytes kept
// for system control, less two tiny device maps.
`define DEVTBL_MAPSZ 30'd892

// Byte address just past the table region.
`define DEVTBL_TBL_END 12'hDF0

// Map sizes of the listed devices, in words.
`define BLOCKDEV_MAPSZ 30'd128
`define TINYDEV_MAPSZ 30'd2
`define RAM_MAPSZ 30'h0040_0000
`define RAMCTRL_MAPSZ 30'd16

// System control window and its registers.
`define SYSCTL_BASE 12'hE00
`define SYSCTL_SEL_OFS 12'h000
`define SYSCTL_RESULT_OFS 12'h004
`define SYSCTL_CMD_OFS 12'h008

// Query results.
`define SOC_VERSION 32'h0001_0203
`define RAM_CACHE_SZ 32'd16384
`define PRELDR_ADDR 32'h0000_1000

`endif
